/* nccMatcher.f */
+incdir+include
src/nccPkg.sv
src/wrapCounter.sv
src/windowCtrl.sv
src/descriptorStore.sv
src/peRow.sv
src/correlationArray.sv
src/bestMatchRegister.sv
src/nccMatcher.sv
dv/nccMatcher_asserts.sv
dv/nccMatcherTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP ?= nccMatcherTb
FILELIST ?= nccMatcher.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/nccTestTasks.svh */
`ifndef NCC_TEST_TASKS_SVH
`define NCC_TEST_TASKS_SVH

// small positive descriptor, every pixel nonzero
function automatic void knownDescriptor();
	for (int p = 0; p < numPixels; p++) begin
		descSource[p] = p % 5 + 1;
	end
endfunction

// base window scaled by factor, score scales with it
function automatic void scaledWindow(input int factor);
	for (int p = 0; p < numPixels; p++) begin
		windowPix[p] = factor * (p % 9);
	end
endfunction

function automatic void randomDescriptor();
	for (int p = 0; p < numPixels; p++) begin
		descSource[p] = $random(seed) % 256;
	end
endfunction

function automatic void randomWindow();
	for (int p = 0; p < numPixels; p++) begin
		windowPix[p] = $random(seed) % 256;
	end
endfunction

task automatic knownPatchTest();
	resetDut();
	knownDescriptor();
	loadDescriptor();
	scaledWindow(1);
	sendWindow();
	// first window after reset lands at index 0
	checkValue("greatestScore", int'(greatestScore), expectedScore());
	checkValue("greatestIndex", int'(greatestIndex), 0);
endtask

task automatic strictGreaterTest();
	int factors [6] = '{1, 3, 2, 3, 5, 4};
	resetDut();
	knownDescriptor();
	loadDescriptor();
	for (int w = 0; w < 6; w++) begin
		scaledWindow(factors[w]);
		sendWindow();
		if (w == 3) begin
			// tie with window 1 keeps the earlier index
			checkValue("greatestIndex", int'(greatestIndex), 1);
		end
	end
	checkValue("greatestIndex", int'(greatestIndex), 4);
endtask

task automatic negativeScoreTest();
	resetDut();
	knownDescriptor();
	loadDescriptor();
	for (int f = 1; f <= 3; f++) begin
		scaledWindow(-f);
		sendWindow();
		checkValue("greatestScore", int'(greatestScore), 0);
		checkValue("greatestIndex", int'(greatestIndex), 0);
	end
endtask

task automatic searchClearTest();
	resetDut();
	knownDescriptor();
	loadDescriptor();
	for (int w = 0; w < windowsPerSearch; w++) begin
		scaledWindow(w + 1);
		sendWindow();
	end
	// idle cycles, the search clear fires on its own
	repeat (4) @(posedge clk);
	@(negedge clk);
	checkValue("greatestScore", int'(greatestScore), 0);
	checkValue("greatestIndex", int'(greatestIndex), 0);
	scaledWindow(2);
	sendWindow();
	checkValue("greatestIndex", int'(greatestIndex), 0);
endtask

// ready stays high, so a window is taken every second cycle
task automatic holdReadyWindows(input int count);
	int score;
	randomWindow();
	score = expectedScore();
	@(posedge clk);
	windowData <= packWindow();
	windowReady <= 1'b1;
	for (int i = 0; i < count; i++) begin
		// this edge accepts window i
		@(posedge clk);
		if (i + 1 < count) begin
			randomWindow();
			windowData <= packWindow();
		end else begin
			windowReady <= 1'b0;
		end
		@(negedge clk);
		checkValue("windowDone", int'(windowDone), 1);
		@(posedge clk);
		recordWindow(score);
		score = expectedScore();
		@(negedge clk);
		checkValue("windowDone", int'(windowDone), 0);
		checkResult();
		applySearchClear();
	end
endtask

task automatic randomReloadTest();
	resetDut();
	for (int round = 0; round < 3; round++) begin
		randomDescriptor();
		loadDescriptor();
		for (int w = 0; w < 3; w++) begin
			randomWindow();
			sendWindow();
		end
	end
	holdReadyWindows(10);
endtask

`endif

/* dv/nccMatcherTb.sv */
`timescale 1ns/1ps

module nccMatcherTb;

	localparam int patchDim = 8;
	localparam int pixelsPerBeat = 4;
	localparam int indexWidth = 13;
	localparam int windowsPerSearch = 8;
	localparam int pw = nccPkg::pixelWidth;
	localparam int numPixels = patchDim * patchDim;
	localparam int beatsPerPatch = numPixels / pixelsPerBeat;
	localparam int clkPeriod = 40;
	localparam int resetCycles = 3;
	localparam int doneLimit = 8;

	// watchdog budget from the test lengths
	localparam int descLoads = 7;
	localparam int windowsSent = 38;
	localparam int cyclesPerWindow = 4;
	localparam int resetsDone = 6;
	localparam int marginCycles = 200;
	localparam int timeoutCycles = descLoads * (beatsPerPatch + 1)
		+ windowsSent * cyclesPerWindow + resetsDone * (resetCycles + 1) + marginCycles;

	logic clk;
	logic rst;
	logic descReady;
	logic [pixelsPerBeat*pw-1:0] descData;
	logic windowReady;
	logic [numPixels*pw-1:0] windowData;
	logic windowDone;
	nccPkg::score_t greatestScore;
	logic [indexWidth-1:0] greatestIndex;

	int seed;
	int checkCount;
	int valueErrors;
	int otherErrors;
	int assertFailures;
	int totalErrors;

	// reference model state
	int descSource [numPixels];
	int descModel [numPixels];
	int windowPix [numPixels];
	int beatPos;
	int windowCountModel;
	int expBestScore;
	int expBestIndex;

	nccMatcher dut_i (
		.clk(clk),
		.rst(rst),
		.descReady(descReady),
		.descData(descData),
		.windowReady(windowReady),
		.windowData(windowData),
		.windowDone(windowDone),
		.greatestScore(greatestScore),
		.greatestIndex(greatestIndex)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clkPeriod / 2) clk = ~clk;
		end
	end

	task automatic checkValue(input string name, input int observed, input int expected);
		checkCount++;
		if (observed !== expected) begin
			valueErrors++;
			$display("** Error: %s is 0x%08h, expected 0x%08h at %0t", name, observed,
				expected, $time);
		end
	endtask

	// exact sum of products over the whole patch
	function automatic int expectedScore();
		int sum;
		sum = 0;
		for (int p = 0; p < numPixels; p++) begin
			sum += descModel[p] * windowPix[p];
		end
		return sum;
	endfunction

	function automatic logic [numPixels*pw-1:0] packWindow();
		logic [numPixels*pw-1:0] bits;
		for (int p = 0; p < numPixels; p++) begin
			bits[p*pw +: pw] = pw'(windowPix[p]);
		end
		return bits;
	endfunction

	// only a strictly greater score replaces the best and keeps the count before the increment
	task automatic recordWindow(input int score);
		if (score > expBestScore) begin
			expBestScore = score;
			expBestIndex = windowCountModel;
		end
		windowCountModel = (windowCountModel + 1) % (1 << indexWidth);
	endtask

	// the DUT clears on the next edge in the waiting state
	task automatic applySearchClear();
		if (windowCountModel == windowsPerSearch) begin
			windowCountModel = 0;
			expBestScore = 0;
			expBestIndex = 0;
		end
	endtask

	task automatic checkResult();
		checkValue("greatestScore", int'(greatestScore), expBestScore);
		checkValue("greatestIndex", int'(greatestIndex), expBestIndex);
	endtask

	task automatic resetDut();
		@(posedge clk);
		rst <= 1'b1;
		descReady <= 1'b0;
		windowReady <= 1'b0;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
		beatPos = 0;
		windowCountModel = 0;
		expBestScore = 0;
		expBestIndex = 0;
		for (int p = 0; p < numPixels; p++) begin
			descModel[p] = 0;
		end
	endtask

	// one beat per cycle with rows top down and column groups left to right
	task automatic loadDescriptor();
		logic [pixelsPerBeat*pw-1:0] beat;
		int base;
		for (int b = 0; b < beatsPerPatch; b++) begin
			base = beatPos * pixelsPerBeat;
			for (int k = 0; k < pixelsPerBeat; k++) begin
				beat[k*pw +: pw] = pw'(descSource[base + k]);
				descModel[base + k] = descSource[base + k];
			end
			@(posedge clk);
			descReady <= 1'b1;
			descData <= beat;
			beatPos = (beatPos + 1) % beatsPerPatch;
		end
		@(posedge clk);
		descReady <= 1'b0;
	endtask

	task automatic waitForDone();
		int waited;
		waited = 0;
		@(negedge clk);
		while (windowDone !== 1'b1 && waited < doneLimit) begin
			waited++;
			@(negedge clk);
		end
		if (windowDone !== 1'b1) begin
			otherErrors++;
			$display("windowDone never came after an accepted window at %0t", $time);
		end else if (waited != 0) begin
			otherErrors++;
			$display("windowDone came %0d cycles later than expected at %0t", waited, $time);
		end
	endtask

	task automatic sendWindow();
		int score;
		score = expectedScore();
		@(posedge clk);
		windowData <= packWindow();
		windowReady <= 1'b1;
		// accepted on this edge
		@(posedge clk);
		windowReady <= 1'b0;
		waitForDone();
		@(posedge clk);
		recordWindow(score);
		@(negedge clk);
		checkValue("windowDone", int'(windowDone), 0);
		checkResult();
		applySearchClear();
	endtask

	`include "nccTestTasks.svh"

	initial begin
		seed = 32'h1030;
		checkCount = 0;
		valueErrors = 0;
		otherErrors = 0;
		rst = 1'b1;
		descReady = 1'b0;
		descData = '0;
		windowReady = 1'b0;
		windowData = '0;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
		knownPatchTest();
		strictGreaterTest();
		negativeScoreTest();
		searchClearTest();
		randomReloadTest();
		repeat (2) @(posedge clk);
		assertFailures = int'(dut_i.windowCtrl_i.ctrlChecks.failCount);
		totalErrors = valueErrors + otherErrors + assertFailures;
		$display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
			checkCount, valueErrors, otherErrors, assertFailures);
		if (totalErrors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (timeoutCycles) @(posedge clk);
		$display("timeout, the tests did not finish within %0d cycles", timeoutCycles);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* dv/nccMatcher_asserts.sv */
`timescale 1ns/1ps

module nccMatcher_asserts (
	input logic clk,
	input logic rst,
	input logic windowReady,
	input logic loadWindow,
	input logic scoreStrobe,
	input nccPkg::winState_t state
);

	int unsigned failCount = 0;

	// score pulse lasts exactly one cycle
	scorePulseOnce: assert property (@(posedge clk) disable iff (rst)
		scoreStrobe |=> !scoreStrobe)
		else begin
			failCount++;
			$error("scoreStrobe high for more than one cycle");
		end

	// accepted ready gives a score one cycle later
	scoreAfterReady: assert property (@(posedge clk) disable iff (rst)
		(state == nccPkg::WIN_WAIT && windowReady) |=> scoreStrobe)
		else begin
			failCount++;
			$error("no scoreStrobe one cycle after an accepted windowReady");
		end

	scoreNeedsLoad: assert property (@(posedge clk) disable iff (rst)
		scoreStrobe |-> $past(loadWindow))
		else begin
			failCount++;
			$error("scoreStrobe without a capture in the cycle before");
		end

	loadScoreApart: assert property (@(posedge clk) disable iff (rst)
		!(loadWindow && scoreStrobe))
		else begin
			failCount++;
			$error("loadWindow and scoreStrobe high together");
		end

endmodule

bind windowCtrl nccMatcher_asserts ctrlChecks (
	.clk(clk),
	.rst(rst),
	.windowReady(windowReady),
	.loadWindow(loadWindow),
	.scoreStrobe(scoreStrobe),
	.state(state)
);

/* src/nccMatcher.sv */
`timescale 1ns/1ps

module nccMatcher #(
	parameter int patchDim = 8,
	parameter int pixelsPerBeat = 4,
	parameter int indexWidth = 13,
	parameter int windowsPerSearch = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic descReady,
	input  logic [pixelsPerBeat*nccPkg::pixelWidth-1:0] descData,
	input  logic windowReady,
	input  logic [patchDim*patchDim*nccPkg::pixelWidth-1:0] windowData,
	output logic windowDone,
	output nccPkg::score_t greatestScore,
	output logic [indexWidth-1:0] greatestIndex
);

	// beats needed to fill one descriptor patch
	localparam int beatCount = patchDim * patchDim / pixelsPerBeat;
	localparam int beatWidth = (beatCount > 1) ? $clog2(beatCount) : 1;

	logic loadWindow;
	logic clearSearch;
	logic [beatWidth-1:0] beatIndex;
	logic [indexWidth-1:0] windowCount;
	logic [patchDim*patchDim*nccPkg::pixelWidth-1:0] descPixels;
	nccPkg::score_t score;

	// windowDone is the controller's score pulse
	windowCtrl #(
		.indexWidth(indexWidth),
		.windowsPerSearch(windowsPerSearch)
	) windowCtrl_i (
		.clk(clk),
		.rst(rst),
		.windowReady(windowReady),
		.windowCount(windowCount),
		.loadWindow(loadWindow),
		.scoreStrobe(windowDone),
		.clearSearch(clearSearch)
	);

	// descriptor beat position, never cleared
	wrapCounter #(
		.width(beatWidth),
		.modulus(beatCount)
	) beatCounter (
		.clk(clk),
		.rst(rst),
		.clear(1'b0),
		.enable(descReady),
		.count(beatIndex)
	);

	// index of the window being scored
	wrapCounter #(
		.width(indexWidth),
		.modulus(2 ** indexWidth)
	) windowCounter (
		.clk(clk),
		.rst(rst),
		.clear(clearSearch),
		.enable(windowDone),
		.count(windowCount)
	);

	descriptorStore #(
		.patchDim(patchDim),
		.pixelsPerBeat(pixelsPerBeat),
		.beatWidth(beatWidth)
	) descriptorStore_i (
		.clk(clk),
		.rst(rst),
		.descReady(descReady),
		.beatIndex(beatIndex),
		.descData(descData),
		.descPixels(descPixels)
	);

	correlationArray #(
		.patchDim(patchDim)
	) correlationArray_i (
		.clk(clk),
		.rst(rst),
		.loadWindow(loadWindow),
		.windowData(windowData),
		.descPixels(descPixels),
		.score(score)
	);

	bestMatchRegister #(
		.indexWidth(indexWidth)
	) bestMatchRegister_i (
		.clk(clk),
		.rst(rst),
		.load(windowDone),
		.clear(clearSearch),
		.score(score),
		.windowIndex(windowCount),
		.bestScore(greatestScore),
		.bestIndex(greatestIndex)
	);

endmodule

/* src/bestMatchRegister.sv */
`timescale 1ns/1ps

module bestMatchRegister #(
	parameter int indexWidth = 13
) (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  logic clear,
	input  nccPkg::score_t score,
	input  logic [indexWidth-1:0] windowIndex,
	output nccPkg::score_t bestScore,
	output logic [indexWidth-1:0] bestIndex
);

	logic isBetter;

	// strictly greater, so a tie keeps the older window
	assign isBetter = score > bestScore;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			bestScore <= '0;
			bestIndex <= '0;
		end else if (clear) begin
			bestScore <= '0;
			bestIndex <= '0;
		end else if (load && isBetter) begin
			bestScore <= score;
			bestIndex <= windowIndex;
		end
	end

endmodule

/* src/correlationArray.sv */
`timescale 1ns/1ps

module correlationArray #(
	parameter int patchDim = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic loadWindow,
	input  logic [patchDim*patchDim*nccPkg::pixelWidth-1:0] windowData,
	input  logic [patchDim*patchDim*nccPkg::pixelWidth-1:0] descPixels,
	output nccPkg::score_t score
);

	localparam int pw = nccPkg::pixelWidth;
	localparam int numPixels = patchDim * patchDim;
	localparam int rowBits = patchDim * pw;

	nccPkg::pixel_t winReg [numPixels];
	logic [rowBits-1:0] winRows [patchDim];
	nccPkg::score_t rowTotals [patchDim];

	// whole window captured in parallel
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int p = 0; p < numPixels; p++) begin
				winReg[p] <= '0;
			end
		end else if (loadWindow) begin
			for (int p = 0; p < numPixels; p++) begin
				winReg[p] <= windowData[p*pw +: pw];
			end
		end
	end

	for (genvar r = 0; r < patchDim; r++) begin : gRow
		for (genvar c = 0; c < patchDim; c++) begin : gCol
			assign winRows[r][c*pw +: pw] = winReg[r*patchDim + c];
		end

		peRow #(
			.patchDim(patchDim)
		) peRow_i (
			.descRow(descPixels[r*rowBits +: rowBits]),
			.winRow(winRows[r]),
			.rowTotal(rowTotals[r])
		);
	end

	// sum of the row totals
	always_comb begin
		score = '0;
		for (int r = 0; r < patchDim; r++) begin
			score = score + rowTotals[r];
		end
	end

endmodule

/* src/peRow.sv */
`timescale 1ns/1ps

module peRow #(
	parameter int patchDim = 8
) (
	input  logic [patchDim*nccPkg::pixelWidth-1:0] descRow,
	input  logic [patchDim*nccPkg::pixelWidth-1:0] winRow,
	output nccPkg::score_t rowTotal
);

	localparam int pw = nccPkg::pixelWidth;

	// partial[c] enters element c from its left neighbor
	nccPkg::score_t partial [patchDim+1];

	assign partial[0] = '0;

	for (genvar c = 0; c < patchDim; c++) begin : gPe
		nccPkg::pixel_t descPx;
		nccPkg::pixel_t winPx;
		nccPkg::score_t product;

		assign descPx = descRow[c*pw +: pw];
		assign winPx = winRow[c*pw +: pw];
		// widen before multiplying so the product is exact
		assign product = nccPkg::score_t'(descPx) * nccPkg::score_t'(winPx);
		assign partial[c+1] = partial[c] + product;
	end

	assign rowTotal = partial[patchDim];

endmodule

/* src/descriptorStore.sv */
`timescale 1ns/1ps

module descriptorStore #(
	parameter int patchDim = 8,
	parameter int pixelsPerBeat = 4,
	parameter int beatWidth = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic descReady,
	input  logic [beatWidth-1:0] beatIndex,
	input  logic [pixelsPerBeat*nccPkg::pixelWidth-1:0] descData,
	output logic [patchDim*patchDim*nccPkg::pixelWidth-1:0] descPixels
);

	localparam int pw = nccPkg::pixelWidth;
	localparam int numPixels = patchDim * patchDim;
	localparam int groupsPerRow = patchDim / pixelsPerBeat;

	nccPkg::pixel_t patch [numPixels];
	int unsigned beatRow;
	int unsigned beatGroup;

	// row and column group of the current beat
	always_comb begin
		beatRow = int'(beatIndex) / groupsPerRow;
		beatGroup = int'(beatIndex) % groupsPerRow;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int p = 0; p < numPixels; p++) begin
				patch[p] <= '0;
			end
		end else if (descReady) begin
			// lowest column of the beat sits in the lowest bits
			for (int k = 0; k < pixelsPerBeat; k++) begin
				patch[beatRow*patchDim + beatGroup*pixelsPerBeat + k] <= descData[k*pw +: pw];
			end
		end
	end

	always_comb begin
		for (int p = 0; p < numPixels; p++) begin
			descPixels[p*pw +: pw] = patch[p];
		end
	end

endmodule

/* src/windowCtrl.sv */
`timescale 1ns/1ps

module windowCtrl #(
	parameter int indexWidth = 13,
	parameter int windowsPerSearch = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic windowReady,
	input  logic [indexWidth-1:0] windowCount,
	output logic loadWindow,
	output logic scoreStrobe,
	output logic clearSearch
);

	localparam logic [indexWidth-1:0] searchEnd = indexWidth'(windowsPerSearch);

	nccPkg::winState_t state;
	nccPkg::winState_t nextState;

	always_comb begin
		loadWindow = 1'b0;
		scoreStrobe = 1'b0;
		clearSearch = 1'b0;
		nextState = state;
		case (state)
			nccPkg::WIN_WAIT: begin
				// search is over once the last window has been scored
				if (windowCount == searchEnd) begin
					clearSearch = 1'b1;
				end
				if (windowReady) begin
					loadWindow = 1'b1;
					nextState = nccPkg::WIN_LOAD;
				end
			end
			nccPkg::WIN_LOAD: begin
				// score is valid this cycle, ready is ignored
				scoreStrobe = 1'b1;
				nextState = nccPkg::WIN_WAIT;
			end
			default: begin
				nextState = nccPkg::WIN_WAIT;
			end
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= nccPkg::WIN_WAIT;
		end else begin
			state <= nextState;
		end
	end

endmodule

/* src/wrapCounter.sv */
`timescale 1ns/1ps

module wrapCounter #(
	parameter int width = 4,
	parameter longint modulus = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic clear,
	input  logic enable,
	output logic [width-1:0] count
);

	localparam logic [width-1:0] lastCount = width'(modulus - 1);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (enable) begin
			// back to zero after the last value
			count <= (count == lastCount) ? '0 : count + 1'b1;
		end
	end

endmodule

/* src/nccPkg.sv */
package nccPkg;

	// bits per signed pixel
	parameter int pixelWidth = 9;

	// bits of the signed correlation score
	parameter int scoreWidth = 32;

	// one signed pixel, descriptor or window
	typedef logic signed [pixelWidth-1:0] pixel_t;

	// raw correlation score, sum of exact products
	typedef logic signed [scoreWidth-1:0] score_t;

	// window controller states
	typedef enum logic {
		WIN_WAIT,
		WIN_LOAD
	} winState_t;

endpackage
